/* source/c64_load_pkg.sv */
//========================================
// Shared types and constants of the file
// loader, imported by every loader module
//========================================
package c64_load_pkg;

	//========================================
	// Sizes
	//========================================
	localparam int OFS_W        = 16;
	localparam int ALIGN_BITS   = 13;
	localparam int CHIP_HDR_LEN = 16;

	typedef logic [7:0]  byte_t;
	typedef logic [24:0] mem_addr_t;
	typedef logic [15:0] word16_t;

	typedef enum logic [1:0] {
		FILE_PRG,
		FILE_CRT,
		FILE_TAP
	} file_kind_e;

	// One beat of the host byte stream
	typedef struct packed {
		byte_t      data;
		file_kind_e kind;
		logic       last;
	} load_byte_t;

	typedef struct packed {
		mem_addr_t addr;
		byte_t     data;
	} mem_wr_t;

	// Cartridge global header fields
	typedef struct packed {
		word16_t id;
		byte_t   exrom;
		byte_t   game;
	} cart_info_t;

	// One record per chip packet
	typedef struct packed {
		byte_t     bank_type;
		word16_t   bank_num;
		word16_t   load_addr;
		word16_t   bank_size;
		mem_addr_t addr;
	} bank_rec_t;

	typedef enum logic [1:0] {
		CHIP_START,
		CHIP_HDR,
		CHIP_DATA
	} chip_byte_e;

	typedef enum logic [2:0] {
		ADDR_HOLD,
		ADDR_SET_LO,
		ADDR_SET_HI,
		ADDR_SET_CRT,
		ADDR_SET_TAP,
		ADDR_CLEAR,
		ADDR_ALIGN,
		ADDR_INC
	} addr_op_e;

	typedef enum logic [1:0] {
		CTRL_IDLE,
		CTRL_LOAD,
		CTRL_ERASE
	} ctrl_state_e;

	//========================================
	// Memory map and file layout
	//========================================
	localparam mem_addr_t CRT_BASE   = 25'h010_0000;
	localparam mem_addr_t TAP_BASE   = 25'h020_0000;
	localparam mem_addr_t ERASE_LAST = 25'h000_FFFF;

	// Packet area start and id offset with EXROM at 0x18 and GAME at 0x19
	localparam logic [OFS_W-1:0] CRT_HDR_END = 16'h0040;
	localparam logic [OFS_W-1:0] CRT_ID_OFS  = 16'h0016;

endpackage

/* source/load_ctrl.sv */
//========================================
// Loader control FSM. Accepts file bytes and
// erase requests, picks the address operation
// and queues memory writes
//========================================
module load_ctrl import c64_load_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset_n,
	input  load_byte_t byte_i,
	input  logic       byte_valid_i,
	output logic       byte_ready_o,
	input  logic       erase_valid_i,
	output logic       erase_ready_o,
	input  logic       queue_full_i,
	input  chip_byte_e byte_class_i,
	input  mem_addr_t  addr_i,
	input  logic       at_erase_end_i,
	output addr_op_e   addr_op_o,
	output byte_t      addr_byte_o,
	output logic       crt_take_o,
	output logic       push_o,
	output mem_wr_t    push_wr_o,
	output cart_info_t cart_info_o,
	output logic       cart_attached_o,
	output mem_addr_t  tap_end_o,
	output logic       load_done_o
);

	ctrl_state_e      state_q;
	logic             live_q;
	logic [OFS_W-1:0] ofs_q;
	logic             byte_take;
	logic             erase_take;
	logic             first_byte;
	logic             file_end;
	mem_addr_t        wr_addr;
	cart_info_t       cart_info_q;
	logic             cart_attached_q;
	mem_addr_t        tap_end_q;
	logic             load_done_q;

	// An erase request wins over a new file in idle
	assign erase_ready_o = live_q && (state_q == CTRL_IDLE);
	assign byte_ready_o  = live_q && !queue_full_i &&
		((state_q == CTRL_LOAD) || ((state_q == CTRL_IDLE) && !erase_valid_i));

	assign erase_take = erase_valid_i && erase_ready_o;
	assign byte_take  = byte_valid_i && byte_ready_o;
	assign first_byte = (ofs_q == '0);
	assign file_end   = byte_take && byte_i.last;

	// First tape byte goes straight to the tape base
	assign wr_addr     = ((byte_i.kind == FILE_TAP) && first_byte) ? TAP_BASE : addr_i;
	assign addr_byte_o = byte_i.data;

	//========================================
	// Per-byte decision
	//========================================
	always_comb begin
		addr_op_o      = ADDR_HOLD;
		crt_take_o     = 1'b0;
		push_o         = 1'b0;
		push_wr_o.addr = wr_addr;
		push_wr_o.data = byte_i.data;
		if (state_q == CTRL_ERASE) begin
			push_wr_o.addr = addr_i;
			push_wr_o.data = {8{addr_i[6]}};
			if (!queue_full_i) begin
				push_o    = 1'b1;
				addr_op_o = ADDR_INC;
			end
		end else if (erase_take) begin
			addr_op_o = ADDR_CLEAR;
		end else if (byte_take) begin
			case (byte_i.kind)
				FILE_PRG: begin
					if (first_byte) begin
						addr_op_o = ADDR_SET_LO;
					end else if (ofs_q == OFS_W'(1)) begin
						addr_op_o = ADDR_SET_HI;
					end else begin
						push_o    = 1'b1;
						addr_op_o = ADDR_INC;
					end
				end
				FILE_CRT: begin
					if (first_byte) begin
						addr_op_o = ADDR_SET_CRT;
					end else if (ofs_q >= CRT_HDR_END) begin
						crt_take_o = 1'b1;
						case (byte_class_i)
							CHIP_START: addr_op_o = ADDR_ALIGN;
							CHIP_DATA: begin
								push_o    = 1'b1;
								addr_op_o = ADDR_INC;
							end
							default: addr_op_o = ADDR_HOLD;
						endcase
					end
				end
				FILE_TAP: begin
					push_o    = 1'b1;
					addr_op_o = first_byte ? ADDR_SET_TAP : ADDR_INC;
				end
				default: addr_op_o = ADDR_HOLD;
			endcase
		end
	end

	//========================================
	// State, offset and status flags
	//========================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			state_q         <= CTRL_IDLE;
			live_q          <= 1'b0;
			ofs_q           <= '0;
			cart_attached_q <= 1'b0;
			load_done_q     <= 1'b0;
		end else begin
			live_q      <= 1'b1;
			load_done_q <= file_end;
			case (state_q)
				CTRL_IDLE: begin
					if (erase_take)
						state_q <= CTRL_ERASE;
					else if (byte_take && !byte_i.last)
						state_q <= CTRL_LOAD;
				end
				CTRL_LOAD: if (file_end) state_q <= CTRL_IDLE;
				CTRL_ERASE: if (!queue_full_i && at_erase_end_i) state_q <= CTRL_IDLE;
				default: state_q <= CTRL_IDLE;
			endcase
			// Offset saturates so long cartridges stay in the packet area
			if (file_end)
				ofs_q <= '0;
			else if (byte_take && (ofs_q != '1))
				ofs_q <= ofs_q + 1'b1;
			if (file_end && (byte_i.kind == FILE_CRT))
				cart_attached_q <= 1'b1;
		end
	end

	// Global cartridge header and tape end
	always_ff @(posedge clk_sys) begin
		if (byte_take && (byte_i.kind == FILE_CRT)) begin
			case (ofs_q)
				CRT_ID_OFS:               cart_info_q.id[15:8] <= byte_i.data;
				CRT_ID_OFS + OFS_W'(1):   cart_info_q.id[7:0]  <= byte_i.data;
				CRT_ID_OFS + OFS_W'(2):   cart_info_q.exrom    <= byte_i.data;
				CRT_ID_OFS + OFS_W'(3):   cart_info_q.game     <= byte_i.data;
				default: ;
			endcase
		end
		if (file_end && (byte_i.kind == FILE_TAP))
			tap_end_q <= wr_addr + 1'b1;
	end

	assign cart_info_o     = cart_info_q;
	assign cart_attached_o = cart_attached_q;
	assign tap_end_o       = tap_end_q;
	assign load_done_o     = load_done_q;

endmodule

/* source/crt_chip_parser.sv */
//========================================
// Cartridge chip packet tracker. Classifies
// each packet byte, assembles the header and
// emits one bank record per packet
//========================================
module crt_chip_parser import c64_load_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset_n,
	input  logic       file_start_i,
	input  logic       byte_take_i,
	input  byte_t      data_i,
	input  mem_addr_t  pkt_addr_i,
	output chip_byte_e byte_class_o,
	output bank_rec_t  bank_o,
	output logic       bank_valid_o
);

	// Header byte index that is zero outside a header
	logic [$clog2(CHIP_HDR_LEN)-1:0] hdr_cnt_q;
	// Packet length while in the header, then data bytes left
	logic [31:0] data_left_q;
	bank_rec_t   rec_q;
	logic        bank_valid_q;

	always_comb begin
		if (hdr_cnt_q != '0)
			byte_class_o = CHIP_HDR;
		else if (data_left_q != '0)
			byte_class_o = CHIP_DATA;
		else
			byte_class_o = CHIP_START;
	end

	//========================================
	// Packet position
	//========================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			hdr_cnt_q    <= '0;
			data_left_q  <= '0;
			bank_valid_q <= 1'b0;
		end else begin
			bank_valid_q <= 1'b0;
			if (file_start_i) begin
				hdr_cnt_q   <= '0;
				data_left_q <= '0;
			end else if (byte_take_i) begin
				case (byte_class_o)
					CHIP_START: hdr_cnt_q <= 4'd1;
					CHIP_HDR: begin
						// Counter wraps to zero after the last header byte
						hdr_cnt_q <= hdr_cnt_q + 1'b1;
						case (hdr_cnt_q)
							4'd4, 4'd5, 4'd6, 4'd7:
								data_left_q <= {data_left_q[23:0], data_i};
							4'd8: begin
								// Length includes the header itself
								if (data_left_q > CHIP_HDR_LEN)
									data_left_q <= data_left_q - CHIP_HDR_LEN;
								else
									data_left_q <= '0;
							end
							4'(CHIP_HDR_LEN - 1): bank_valid_q <= 1'b1;
							default: ;
						endcase
					end
					default: data_left_q <= data_left_q - 1'b1;
				endcase
			end
		end
	end

	// Big-endian header fields
	always_ff @(posedge clk_sys) begin
		if (byte_take_i && (byte_class_o == CHIP_HDR)) begin
			case (hdr_cnt_q)
				4'd9:  rec_q.bank_type       <= data_i;
				4'd10: rec_q.bank_num[15:8]  <= data_i;
				4'd11: rec_q.bank_num[7:0]   <= data_i;
				4'd12: rec_q.load_addr[15:8] <= data_i;
				4'd13: rec_q.load_addr[7:0]  <= data_i;
				4'd14: rec_q.bank_size[15:8] <= data_i;
				4'd15: begin
					rec_q.bank_size[7:0] <= data_i;
					// Address was aligned at header byte 0
					rec_q.addr           <= pkt_addr_i;
				end
				default: ;
			endcase
		end
	end

	assign bank_o       = rec_q;
	assign bank_valid_o = bank_valid_q;

endmodule

/* source/load_addr_gen.sv */
//========================================
// Write address register of the loader with
// byte loads, fixed bases, 8 KB round-up and
// erase end detection
//========================================
module load_addr_gen import c64_load_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset_n,
	input  addr_op_e  op_i,
	input  byte_t     byte_i,
	output mem_addr_t addr_o,
	output logic      at_erase_end_o
);

	mem_addr_t addr_q;
	logic      aligned;
	mem_addr_t addr_up;

	assign aligned = (addr_q[ALIGN_BITS-1:0] == '0);
	// Next 8 KB boundary above the current address
	assign addr_up = {addr_q[$bits(mem_addr_t)-1:ALIGN_BITS] + 1'b1, {ALIGN_BITS{1'b0}}};

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			addr_q <= '0;
		end else begin
			case (op_i)
				// Low byte clears everything above it
				ADDR_SET_LO:  addr_q <= {{($bits(mem_addr_t) - 8){1'b0}}, byte_i};
				ADDR_SET_HI:  addr_q[15:8] <= byte_i;
				ADDR_SET_CRT: addr_q <= CRT_BASE;
				// The first tape byte is written at the base itself
				ADDR_SET_TAP: addr_q <= TAP_BASE + 1'b1;
				ADDR_CLEAR:   addr_q <= '0;
				ADDR_ALIGN: begin
					if (!aligned)
						addr_q <= addr_up;
				end
				ADDR_INC:     addr_q <= addr_q + 1'b1;
				default:      addr_q <= addr_q;
			endcase
		end
	end

	assign addr_o         = addr_q;
	assign at_erase_end_o = (addr_q == ERASE_LAST);

endmodule

/* source/mem_write_queue.sv */
//========================================
// Two-entry write FIFO in front of the
// memory port, valid/ready on the output
//========================================
module mem_write_queue import c64_load_pkg::*; (
	input  logic    clk_sys,
	input  logic    reset_n,
	input  logic    push_i,
	input  mem_wr_t wr_i,
	output logic    full_o,
	output mem_wr_t wr_o,
	output logic    valid_o,
	input  logic    ready_i
);

	mem_wr_t    slot_q [2];
	logic [1:0] count_q;
	logic       wr_ptr_q;
	logic       rd_ptr_q;
	logic       push_ok;
	logic       pop;

	assign full_o  = (count_q == 2'd2);
	assign valid_o = (count_q != 2'd0);
	assign wr_o    = slot_q[rd_ptr_q];
	assign push_ok = push_i && !full_o;
	assign pop     = valid_o && ready_i;

	always_ff @(posedge clk_sys) begin
		if (push_ok)
			slot_q[wr_ptr_q] <= wr_i;
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			count_q  <= 2'd0;
			wr_ptr_q <= 1'b0;
			rd_ptr_q <= 1'b0;
		end else begin
			if (push_ok)
				wr_ptr_q <= ~wr_ptr_q;
			if (pop)
				rd_ptr_q <= ~rd_ptr_q;
			case ({push_ok, pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

endmodule

/* source/c64_loader.sv */
//========================================
// File loader top. Host byte stream in,
// memory writes and cartridge status out
//========================================
module c64_loader import c64_load_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset_n,
	input  load_byte_t byte_i,
	input  logic       byte_valid_i,
	output logic       byte_ready_o,
	input  logic       erase_valid_i,
	output logic       erase_ready_o,
	output mem_wr_t    mem_wr_o,
	output logic       mem_valid_o,
	input  logic       mem_ready_i,
	output cart_info_t cart_info_o,
	output bank_rec_t  bank_o,
	output logic       bank_valid_o,
	output logic       cart_attached_o,
	output mem_addr_t  tap_end_o,
	output logic       load_done_o
);

	logic       queue_full;
	chip_byte_e byte_class;
	mem_addr_t  addr;
	logic       at_erase_end;
	addr_op_e   addr_op;
	byte_t      addr_byte;
	logic       crt_take;
	logic       push;
	mem_wr_t    push_wr;

	load_ctrl load_ctrl_i (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.byte_i          (byte_i),
		.byte_valid_i    (byte_valid_i),
		.byte_ready_o    (byte_ready_o),
		.erase_valid_i   (erase_valid_i),
		.erase_ready_o   (erase_ready_o),
		.queue_full_i    (queue_full),
		.byte_class_i    (byte_class),
		.addr_i          (addr),
		.at_erase_end_i  (at_erase_end),
		.addr_op_o       (addr_op),
		.addr_byte_o     (addr_byte),
		.crt_take_o      (crt_take),
		.push_o          (push),
		.push_wr_o       (push_wr),
		.cart_info_o     (cart_info_o),
		.cart_attached_o (cart_attached_o),
		.tap_end_o       (tap_end_o),
		.load_done_o     (load_done_o)
	);

	// The end of each file restarts packet tracking
	crt_chip_parser crt_chip_parser_i (
		.clk_sys      (clk_sys),
		.reset_n      (reset_n),
		.file_start_i (load_done_o),
		.byte_take_i  (crt_take),
		.data_i       (byte_i.data),
		.pkt_addr_i   (addr),
		.byte_class_o (byte_class),
		.bank_o       (bank_o),
		.bank_valid_o (bank_valid_o)
	);

	load_addr_gen load_addr_gen_i (
		.clk_sys        (clk_sys),
		.reset_n        (reset_n),
		.op_i           (addr_op),
		.byte_i         (addr_byte),
		.addr_o         (addr),
		.at_erase_end_o (at_erase_end)
	);

	mem_write_queue mem_write_queue_i (
		.clk_sys (clk_sys),
		.reset_n (reset_n),
		.push_i  (push),
		.wr_i    (push_wr),
		.full_o  (queue_full),
		.wr_o    (mem_wr_o),
		.valid_o (mem_valid_o),
		.ready_i (mem_ready_i)
	);

endmodule

/* include/loader_model.svh */
//========================================
// Loader reference model for the testbench.
// Include inside the testbench module after
// the loader package import
//========================================
`ifndef LOADER_MODEL_SVH
`define LOADER_MODEL_SVH

// Expected results that the checks consume in order
mem_wr_t    exp_wr_q[$];
bank_rec_t  exp_bank_q[$];
cart_info_t exp_cart;
mem_addr_t  exp_tap_end;

// Round up to the next 8 KB boundary
function automatic mem_addr_t model_align(input mem_addr_t addr);
	mem_addr_t up;
	up = addr;
	if (addr[ALIGN_BITS-1:0] != '0) begin
		up[ALIGN_BITS-1:0] = '0;
		up = up + (mem_addr_t'(1) << ALIGN_BITS);
	end
	return up;
endfunction

function automatic void model_write(input mem_addr_t addr, input byte_t data);
	mem_wr_t wr;
	wr.addr = addr;
	wr.data = data;
	exp_wr_q.push_back(wr);
endfunction

// Expand one file into expected writes and records
function automatic void model_file(input file_kind_e kind, input byte_t file_q[$]);
	mem_addr_t   addr;
	bank_rec_t   rec;
	logic [31:0] len;
	logic [31:0] left;
	int          pos;
	case (kind)
		FILE_PRG: begin
			addr = mem_addr_t'({file_q[1], file_q[0]});
			for (int i = 2; i < file_q.size(); i++) begin
				model_write(addr, file_q[i]);
				addr = addr + 1'b1;
			end
		end
		FILE_CRT: begin
			exp_cart.id    = {file_q[CRT_ID_OFS], file_q[CRT_ID_OFS + 1]};
			exp_cart.exrom = file_q[CRT_ID_OFS + 2];
			exp_cart.game  = file_q[CRT_ID_OFS + 3];
			addr = CRT_BASE;
			pos  = int'(CRT_HDR_END);
			while (pos + CHIP_HDR_LEN <= file_q.size()) begin
				addr          = model_align(addr);
				len           = {file_q[pos+4], file_q[pos+5], file_q[pos+6], file_q[pos+7]};
				rec.bank_type = file_q[pos+9];
				rec.bank_num  = {file_q[pos+10], file_q[pos+11]};
				rec.load_addr = {file_q[pos+12], file_q[pos+13]};
				rec.bank_size = {file_q[pos+14], file_q[pos+15]};
				rec.addr      = addr;
				exp_bank_q.push_back(rec);
				pos  = pos + CHIP_HDR_LEN;
				left = (len > CHIP_HDR_LEN) ? len - CHIP_HDR_LEN : '0;
				while ((left != '0) && (pos < file_q.size())) begin
					model_write(addr, file_q[pos]);
					addr = addr + 1'b1;
					pos  = pos + 1;
					left = left - 1'b1;
				end
			end
		end
		FILE_TAP: begin
			addr = TAP_BASE;
			foreach (file_q[i]) begin
				model_write(addr, file_q[i]);
				addr = addr + 1'b1;
			end
			exp_tap_end = addr;
		end
		default: ;
	endcase
endfunction

// Erase pattern is 0xFF where address bit 6 is set
function automatic void model_erase();
	for (int a = 0; a <= int'(ERASE_LAST); a++)
		model_write(mem_addr_t'(a), {8{a[6]}});
endfunction

`endif

/* tb/tb_c64_loader.sv */
//========================================
// Testbench for the file loader. Streams a
// random program, cartridge and tape file,
// then an erase, and checks every result
//========================================
module tb_c64_loader import c64_load_pkg::*; ();

	localparam int CLK_PERIOD = 10;
	localparam int N_PACKETS  = 3;

	logic       clk_sys;
	logic       reset_n;
	load_byte_t byte_i;
	logic       byte_valid_i;
	logic       byte_ready_o;
	logic       erase_valid_i;
	logic       erase_ready_o;
	mem_wr_t    mem_wr_o;
	logic       mem_valid_o;
	logic       mem_ready_i;
	cart_info_t cart_info_o;
	bank_rec_t  bank_o;
	logic       bank_valid_o;
	logic       cart_attached_o;
	mem_addr_t  tap_end_o;
	logic       load_done_o;

	integer  seed         = 32'h49f5_9158;
	// Separate stream for the memory stall pattern
	integer  ready_seed   = 32'h49f5_9158 ^ 32'h0000_5a5a;
	int      limit_cycles = 0;
	byte_t   prg_file[$];
	byte_t   crt_file[$];
	byte_t   tap_file[$];
	logic    hold_wr = 1'b0;
	mem_wr_t held_wr;

`include "loader_model.svh"

	c64_loader c64_loader_i (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.byte_i          (byte_i),
		.byte_valid_i    (byte_valid_i),
		.byte_ready_o    (byte_ready_o),
		.erase_valid_i   (erase_valid_i),
		.erase_ready_o   (erase_ready_o),
		.mem_wr_o        (mem_wr_o),
		.mem_valid_o     (mem_valid_o),
		.mem_ready_i     (mem_ready_i),
		.cart_info_o     (cart_info_o),
		.bank_o          (bank_o),
		.bank_valid_o    (bank_valid_o),
		.cart_attached_o (cart_attached_o),
		.tap_end_o       (tap_end_o),
		.load_done_o     (load_done_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	//========================================
	// Compare tasks
	//========================================
	task automatic check_wr(input mem_wr_t got, input mem_wr_t exp, input string what);
		if (got !== exp) begin
			$display("ERR %0t: %s addr %h data %h, expected addr %h data %h",
				$time, what, got.addr, got.data, exp.addr, exp.data);
			$display("test failed");
			$fatal(1, "%s mismatch", what);
		end
	endtask

	task automatic check_bank(input bank_rec_t got, input bank_rec_t exp, input string what);
		if (got !== exp) begin
			$display("ERR %0t: %s got type %h num %h load %h size %h addr %h", $time, what,
				got.bank_type, got.bank_num, got.load_addr, got.bank_size, got.addr);
			$display("ERR %0t: %s exp type %h num %h load %h size %h addr %h", $time, what,
				exp.bank_type, exp.bank_num, exp.load_addr, exp.bank_size, exp.addr);
			$display("test failed");
			$fatal(1, "%s mismatch", what);
		end
	endtask

	task automatic check_cart(input cart_info_t got, input cart_info_t exp, input string what);
		if (got !== exp) begin
			$display("ERR %0t: %s id %h exrom %h game %h, expected id %h exrom %h game %h",
				$time, what, got.id, got.exrom, got.game, exp.id, exp.exrom, exp.game);
			$display("test failed");
			$fatal(1, "%s mismatch", what);
		end
	endtask

	task automatic check_addr(input mem_addr_t got, input mem_addr_t exp, input string what);
		if (got !== exp) begin
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
			$display("test failed");
			$fatal(1, "%s mismatch", what);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
			$display("test failed");
			$fatal(1, "%s mismatch", what);
		end
	endtask

	//========================================
	// Stimulus
	//========================================
	task automatic build_files();
		int          n;
		int          dlen;
		logic [31:0] plen;
		byte_t       b;
		// Program file with the load address ahead of the payload
		n = 22 + int'($unsigned($random(seed)) % 31);
		for (int i = 0; i < n; i++)
			prg_file.push_back(byte_t'($random(seed)));
		// Cartridge global header followed by the chip packets
		for (int i = 0; i < int'(CRT_HDR_END); i++)
			crt_file.push_back(byte_t'($random(seed)));
		for (int p = 0; p < N_PACKETS; p++) begin
			dlen = int'($unsigned($random(seed)) % 48);
			plen = 32'(dlen + CHIP_HDR_LEN);
			for (int h = 0; h < CHIP_HDR_LEN; h++) begin
				if ((h >= 4) && (h <= 7))
					b = plen[8*(7-h) +: 8];
				else
					b = byte_t'($random(seed));
				crt_file.push_back(b);
			end
			for (int i = 0; i < dlen; i++)
				crt_file.push_back(byte_t'($random(seed)));
		end
		n = 30 + int'($unsigned($random(seed)) % 31);
		for (int i = 0; i < n; i++)
			tap_file.push_back(byte_t'($random(seed)));
	endtask

	// Entered and left a short delay after a rising edge
	task automatic send_file(input file_kind_e kind, input byte_t file_q[$]);
		int gap;
		foreach (file_q[i]) begin
			gap = int'($unsigned($random(seed)) % 3);
			repeat (gap) begin
				@(posedge clk_sys);
				#1;
			end
			byte_i.data  = file_q[i];
			byte_i.kind  = kind;
			byte_i.last  = (i == file_q.size() - 1);
			byte_valid_i = 1'b1;
			@(negedge clk_sys);
			while (!byte_ready_o)
				@(negedge clk_sys);
			// The done pulse only follows the last byte of a file
			check_flag(load_done_o, 1'b0, "load_done_o before last byte");
			@(posedge clk_sys);
			#1;
			byte_valid_i = 1'b0;
		end
		@(negedge clk_sys);
		check_flag(load_done_o, 1'b1, "load_done_o after last byte");
		@(posedge clk_sys);
		#1;
	endtask

	task automatic run_erase();
		@(negedge clk_sys);
		while (!erase_ready_o)
			@(negedge clk_sys);
		@(posedge clk_sys);
		#1;
		erase_valid_i = 1'b1;
		@(negedge clk_sys);
		while (!erase_ready_o)
			@(negedge clk_sys);
		@(posedge clk_sys);
		#1;
		erase_valid_i = 1'b0;
		@(negedge clk_sys);
		// No file byte is taken while the erase runs
		while (!erase_ready_o) begin
			check_flag(byte_ready_o, 1'b0, "byte_ready_o during erase");
			@(negedge clk_sys);
		end
	endtask

	initial begin
		reset_n       = 1'b0;
		byte_i        = '0;
		byte_valid_i  = 1'b0;
		erase_valid_i = 1'b0;
		build_files();
		model_file(FILE_PRG, prg_file);
		model_file(FILE_CRT, crt_file);
		model_file(FILE_TAP, tap_file);
		model_erase();
		limit_cycles = (prg_file.size() + crt_file.size() + tap_file.size() + 65536) * 4 + 64;
		repeat (16) @(posedge clk_sys);
		#1;
		reset_n = 1'b1;
		@(negedge clk_sys);
		check_flag(mem_valid_o, 1'b0, "mem_valid_o after reset");
		check_flag(bank_valid_o, 1'b0, "bank_valid_o after reset");
		check_flag(cart_attached_o, 1'b0, "cart_attached_o after reset");
		@(posedge clk_sys);
		#1;
		send_file(FILE_PRG, prg_file);
		check_flag(cart_attached_o, 1'b0, "cart_attached_o after program file");
		send_file(FILE_CRT, crt_file);
		check_cart(cart_info_o, exp_cart, "cart_info_o");
		check_flag(cart_attached_o, 1'b1, "cart_attached_o after cartridge");
		send_file(FILE_TAP, tap_file);
		check_addr(tap_end_o, exp_tap_end, "tap_end_o");
		run_erase();
		while (exp_wr_q.size() != 0)
			@(negedge clk_sys);
		repeat (4) @(negedge clk_sys);
		check_flag(mem_valid_o, 1'b0, "mem_valid_o after drain");
		if (exp_bank_q.size() != 0) begin
			$display("%0d bank records were expected but never emitted", exp_bank_q.size());
			$display("test failed");
			$fatal(1, "missing bank records");
		end else begin
			$display("test passed");
			$finish;
		end
	end

	// Random memory stalls in about one cycle of four
	initial begin
		mem_ready_i = 1'b0;
		forever begin
			@(posedge clk_sys);
			#1;
			mem_ready_i = (($random(ready_seed) & 3) != 0);
		end
	end

	//========================================
	// Output monitors sampled mid-cycle
	//========================================
	always @(negedge clk_sys) begin
		if (reset_n) begin
			if (hold_wr) begin
				check_flag(mem_valid_o, 1'b1, "mem_valid_o during stall");
				check_wr(mem_wr_o, held_wr, "stalled write");
			end
			if (mem_valid_o && mem_ready_i) begin
				if (exp_wr_q.size() == 0) begin
					$display("Memory write to %h at %0t with no write expected",
						mem_wr_o.addr, $time);
					$display("test failed");
					$fatal(1, "unexpected write");
				end else begin
					check_wr(mem_wr_o, exp_wr_q.pop_front(), "memory write");
				end
			end
			hold_wr = mem_valid_o && !mem_ready_i;
			held_wr = mem_wr_o;
		end
	end

	always @(negedge clk_sys) begin
		if (reset_n && bank_valid_o) begin
			if (exp_bank_q.size() == 0) begin
				$display("Bank record emitted at %0t with none expected", $time);
				$display("test failed");
				$fatal(1, "unexpected bank record");
			end else begin
				check_bank(bank_o, exp_bank_q.pop_front(), "bank record");
			end
		end
	end

	initial begin
		wait (limit_cycles != 0);
		repeat (limit_cycles) @(posedge clk_sys);
		$display("Watchdog expired: the run did not finish within %0d cycles", limit_cycles);
		$display("test failed");
		$fatal(1, "timeout");
	end

endmodule

/* tb.f */
+incdir+include
source/c64_load_pkg.sv
source/load_ctrl.sv
source/crt_chip_parser.sv
source/load_addr_gen.sv
source/mem_write_queue.sv
source/c64_loader.sv
tb/tb_c64_loader.sv

/* run.sh */
#!/bin/bash
# Build and run the loader testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -f tb.f --top-module tb_c64_loader

# The simulation exits non-zero on failure, the grep decides the result
output=$(./obj_dir/Vtb_c64_loader 2>&1) || true
echo "$output"

if echo "$output" | grep -q "^test passed$"; then
	exit 0
else
	exit 1
fi
